// ==== hw/bp_pkg.sv ====
`default_nettype none

package bp_pkg;

	//////////////////////////////
	// table geometry
	//////////////////////////////

	// halfword program counter
	localparam int PC_W = 11;
	// set index comes from pc[3:0] and the tag from pc[9:4]
	localparam int SET_W = 4;
	localparam int TAG_W = 6;
	localparam int WAYS = 4;
	localparam int SETS = 16;
	localparam int WAY_W = 2;

	// 2-bit saturating counter, msb is the taken prediction
	localparam int CTR_W = 2;
	// branches start weakly not taken
	localparam logic [CTR_W-1:0] CTR_BRANCH_INIT = 2'd1;
	// jumps start strongly taken
	localparam logic [CTR_W-1:0] CTR_JUMP_INIT = 2'd3;

	// one-hot branch kind positions in bp_exe_t
	localparam int BT_BEQ = 5;
	localparam int BT_BNE = 4;
	localparam int BT_BLT = 3;
	localparam int BT_BGE = 2;
	localparam int BT_BLTU = 1;
	localparam int BT_BGEU = 0;
	localparam int CBT_BEQZ = 1;
	localparam int CBT_BNEZ = 0;

	//////////////////////////////
	// entry and port types
	//////////////////////////////

	typedef struct packed {
		logic valid;
		logic [TAG_W-1:0] tag;
		logic [PC_W-1:0] target;
		logic [CTR_W-1:0] ctr;
	} bht_entry_t;

	// all ways of one set, way 0 in the low bits
	typedef bht_entry_t [WAYS-1:0] bht_set_t;

	typedef struct packed {
		logic prediction;
		logic [PC_W-1:0] pbt;
	} bp_fetch_t;

	typedef struct packed {
		logic [PC_W-1:0] pc;
		logic [PC_W-1:0] target;
		logic is_jump;
		logic is_btype;
	} bp_decode_t;

	// z and less are the alu flags of the resolving branch
	typedef struct packed {
		logic [PC_W-1:0] pc;
		logic z;
		logic less;
		logic [5:0] btype;
		logic [1:0] c_btype;
	} bp_exe_t;

	typedef struct packed {
		logic we;
		logic [SET_W-1:0] set;
		bht_entry_t entry;
	} bht_alloc_t;

	typedef struct packed {
		logic we;
		logic [SET_W-1:0] set;
		logic [WAY_W-1:0] way;
		logic [CTR_W-1:0] ctr;
	} bht_update_t;

	// next pc select from execute, NONE keeps the normal flow
	typedef enum logic [1:0] {
		NONE = 2'd0,
		CNI = 2'd2,
		PBT = 2'd3
	} bp_correction_e;

	// pc field extraction
	function automatic logic [SET_W-1:0] pc_set(input logic [PC_W-1:0] pc);
		return pc[SET_W-1:0];
	endfunction

	function automatic logic [TAG_W-1:0] pc_tag(input logic [PC_W-1:0] pc);
		return pc[SET_W+TAG_W-1:SET_W];
	endfunction

endpackage

`default_nettype wire

// ==== hw/bht_way_match.sv ====
`timescale 1ns/1ns
`default_nettype none

module bht_way_match (
	input bp_pkg::bht_set_t set_entries,
	input logic [bp_pkg::TAG_W-1:0] tag,
	output logic hit,
	output logic [bp_pkg::WAY_W-1:0] way,
	output bp_pkg::bht_entry_t entry
);

	// per-way tag compare
	logic [bp_pkg::WAYS-1:0] match;

	always_comb begin
		for (int i = 0; i < bp_pkg::WAYS; i++) begin
			// only a valid way can hit
			match[i] = set_entries[i].valid && (set_entries[i].tag == tag);
		end
	end

	//////////////////////////////
	// one-hot select
	//////////////////////////////

	// several hits count as a miss
	// entry and way stay zero then
	always_comb begin
		hit = $onehot(match);
		way = '0;
		entry = '0;
		for (int i = 0; i < bp_pkg::WAYS; i++) begin
			if (hit && match[i]) begin
				way = i[bp_pkg::WAY_W-1:0];
				entry = set_entries[i];
			end
		end
	end

endmodule

`default_nettype wire

// ==== hw/bht_table.sv ====
`timescale 1ns/1ns
`default_nettype none

module bht_table (
	input logic CLK,
	input logic nrst,
	input logic en,

	// three combinational read ports
	input logic [bp_pkg::SET_W-1:0] if_set,
	input logic [bp_pkg::SET_W-1:0] id_set,
	input logic [bp_pkg::SET_W-1:0] exe_set,
	output bp_pkg::bht_set_t if_ways,
	output bp_pkg::bht_set_t id_ways,
	output bp_pkg::bht_set_t exe_ways,

	// write requests from decode and execute
	input bp_pkg::bht_alloc_t alloc,
	input bp_pkg::bht_update_t upd
);

	//////////////////////////////
	// storage
	//////////////////////////////

	// one row per set holding all four ways
	bp_pkg::bht_set_t mem [bp_pkg::SETS];

	// fifo replacement pointer per set
	// points at the oldest way
	logic [bp_pkg::WAY_W-1:0] fifo_ptr [bp_pkg::SETS];

	// qualified write strobes
	logic alloc_wr;
	logic upd_wr;
	// way chosen for the allocation
	logic [bp_pkg::WAY_W-1:0] alloc_way;

	//////////////////////////////
	// reads
	//////////////////////////////

	// no bypass, a write shows up the cycle after the edge
	assign if_ways = mem[if_set];
	assign id_ways = mem[id_set];
	assign exe_ways = mem[exe_set];

	//////////////////////////////
	// write arbitration
	//////////////////////////////

	// allocation wins over a counter update in the same cycle
	// the losing update is simply dropped
	assign alloc_wr = en && alloc.we;
	assign upd_wr = en && upd.we && !alloc.we;

	assign alloc_way = fifo_ptr[alloc.set];

	always_ff @(posedge CLK) begin
		if (!nrst) begin
			// every entry invalid, every pointer at way 0
			for (int s = 0; s < bp_pkg::SETS; s++) begin
				mem[s] <= '0;
				fifo_ptr[s] <= '0;
			end
		end else begin
			if (alloc_wr) begin
				// replace the oldest way of the set
				mem[alloc.set][alloc_way] <= alloc.entry;
				// 2-bit pointer wraps modulo 4
				fifo_ptr[alloc.set] <= alloc_way + 1'b1;
			end else if (upd_wr) begin
				// only the counter field changes on an update
				mem[upd.set][upd.way].ctr <= upd.ctr;
			end
		end
	end

endmodule

`default_nettype wire

// ==== hw/bp_decode_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

module bp_decode_stage (
	input bp_pkg::bp_decode_t id_in,
	input bp_pkg::bht_set_t id_ways,
	output logic [bp_pkg::SET_W-1:0] id_set,
	output bp_pkg::bht_alloc_t alloc,
	output logic jump_alloc,
	output logic id_jump_in_bht
);

	logic [bp_pkg::TAG_W-1:0] id_tag;
	logic id_hit;
	// branch or jump seen at decode
	logic is_ctrl;

	assign id_set = bp_pkg::pc_set(id_in.pc);
	assign id_tag = bp_pkg::pc_tag(id_in.pc);

	// decode lookup, only hit is needed here
	bht_way_match u_id_match (
		.set_entries(id_ways),
		.tag(id_tag),
		.hit(id_hit),
		.way(),
		.entry()
	);

	assign is_ctrl = id_in.is_jump || id_in.is_btype;

	//////////////////////////////
	// allocation
	//////////////////////////////

	// a missing branch or jump gets a fresh entry
	// the table picks the way from its fifo pointer
	always_comb begin
		alloc.we = is_ctrl && !id_hit;
		alloc.set = id_set;
		alloc.entry.valid = 1'b1;
		alloc.entry.tag = id_tag;
		alloc.entry.target = id_in.target;
		// jumps are always taken
		alloc.entry.ctr = id_in.is_jump ? bp_pkg::CTR_JUMP_INIT : bp_pkg::CTR_BRANCH_INIT;
	end

	// new jump means fetch went the wrong way, flush follows one cycle later
	assign jump_alloc = id_in.is_jump && !id_hit;

	// known jump, core can use the stored target
	assign id_jump_in_bht = id_in.is_jump && id_hit;

endmodule

`default_nettype wire

// ==== hw/bp_resolve_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

module bp_resolve_stage (
	input bp_pkg::bp_exe_t exe_in,
	input bp_pkg::bht_set_t exe_ways,
	output logic [bp_pkg::SET_W-1:0] exe_set,
	output bp_pkg::bht_update_t upd,
	output logic mispredict,
	output bp_pkg::bp_correction_e exe_correction,
	output logic [bp_pkg::PC_W-1:0] exe_pbt,
	output logic [bp_pkg::PC_W-1:0] exe_cni
);

	logic [bp_pkg::TAG_W-1:0] exe_tag;
	logic exe_hit;
	logic [bp_pkg::WAY_W-1:0] exe_way;
	bp_pkg::bht_entry_t exe_entry;

	// resolved outcome and the prediction made for it
	logic taken;
	logic is_branch;
	logic pred;
	logic [bp_pkg::CTR_W-1:0] next_ctr;

	assign exe_set = bp_pkg::pc_set(exe_in.pc);
	assign exe_tag = bp_pkg::pc_tag(exe_in.pc);

	bht_way_match u_exe_match (
		.set_entries(exe_ways),
		.tag(exe_tag),
		.hit(exe_hit),
		.way(exe_way),
		.entry(exe_entry)
	);

	//////////////////////////////
	// condition evaluation
	//////////////////////////////

	// btype is one-hot so at most one term is live
	// compressed forms test z like beq and bne
	assign taken =
		(exe_in.btype[bp_pkg::BT_BEQ] && exe_in.z) ||
		(exe_in.btype[bp_pkg::BT_BNE] && !exe_in.z) ||
		(exe_in.btype[bp_pkg::BT_BLT] && exe_in.less) ||
		(exe_in.btype[bp_pkg::BT_BGE] && !exe_in.less) ||
		(exe_in.btype[bp_pkg::BT_BLTU] && exe_in.less) ||
		(exe_in.btype[bp_pkg::BT_BGEU] && !exe_in.less) ||
		(exe_in.c_btype[bp_pkg::CBT_BEQZ] && exe_in.z) ||
		(exe_in.c_btype[bp_pkg::CBT_BNEZ] && !exe_in.z);

	assign is_branch = (|exe_in.btype) || (|exe_in.c_btype);

	// a miss predicted not taken at fetch
	assign pred = exe_hit && exe_entry.ctr[bp_pkg::CTR_W-1];

	//////////////////////////////
	// counter update
	//////////////////////////////

	// one step toward the outcome, saturating at 0 and 3
	always_comb begin
		next_ctr = exe_entry.ctr;
		if (taken && (exe_entry.ctr != {bp_pkg::CTR_W{1'b1}}))
			next_ctr = exe_entry.ctr + 1'b1;
		else if (!taken && (exe_entry.ctr != '0))
			next_ctr = exe_entry.ctr - 1'b1;
	end

	// only entries already in the table are trained
	always_comb begin
		upd.we = is_branch && exe_hit;
		upd.set = exe_set;
		upd.way = exe_way;
		upd.ctr = next_ctr;
	end

	//////////////////////////////
	// correction
	//////////////////////////////

	assign mispredict = is_branch && (pred != taken);

	// taken but predicted not taken -> go to the stored target
	// not taken but predicted taken -> fall through
	always_comb begin
		exe_correction = bp_pkg::NONE;
		if (mispredict)
			exe_correction = taken ? bp_pkg::PBT : bp_pkg::CNI;
	end

	assign exe_pbt = exe_entry.target;
	// next halfword after the branch
	assign exe_cni = exe_in.pc + 1'b1;

endmodule

`default_nettype wire

// ==== hw/bp_flush_ctrl.sv ====
`timescale 1ns/1ns
`default_nettype none

module bp_flush_ctrl (
	input logic CLK,
	input logic nrst,
	input logic en,
	input logic mispredict,
	input logic jump_alloc,
	output logic flush
);

	// pending second flush cycle
	logic flush_pend;

	//////////////////////////////
	// extension state
	//////////////////////////////

	// armed by a mispredict or a new jump
	// a set state always clears on the next enabled edge
	// and cannot re-arm in the same cycle
	always_ff @(posedge CLK) begin
		if (!nrst) begin
			flush_pend <= 1'b0;
		end else if (en) begin
			if (flush_pend)
				flush_pend <= 1'b0;
			else
				flush_pend <= mispredict || jump_alloc;
		end
	end

	//////////////////////////////
	// flush output
	//////////////////////////////

	// mispredict flushes at once
	// a jump allocation only through the pending state
	assign flush = flush_pend || mispredict;

endmodule

`default_nettype wire

// ==== hw/branch_predictor.sv ====
`timescale 1ns/1ns
`default_nettype none

module branch_predictor (
	input logic CLK,
	input logic nrst,
	// global stall, low holds all state
	input logic en,

	input logic [bp_pkg::PC_W-1:0] if_pc,
	input bp_pkg::bp_decode_t id_in,
	input bp_pkg::bp_exe_t exe_in,

	output bp_pkg::bp_fetch_t if_out,
	output bp_pkg::bp_correction_e exe_correction,
	output logic [bp_pkg::PC_W-1:0] exe_pbt,
	output logic [bp_pkg::PC_W-1:0] exe_cni,
	output logic flush,
	output logic id_jump_in_bht
);

	// set indices for the three readers
	logic [bp_pkg::SET_W-1:0] if_set;
	logic [bp_pkg::SET_W-1:0] id_set;
	logic [bp_pkg::SET_W-1:0] exe_set;
	bp_pkg::bht_set_t if_ways;
	bp_pkg::bht_set_t id_ways;
	bp_pkg::bht_set_t exe_ways;

	bp_pkg::bht_entry_t if_entry;
	bp_pkg::bht_alloc_t alloc;
	bp_pkg::bht_update_t upd;
	logic mispredict;
	logic jump_alloc;

	//////////////////////////////
	// shared table
	//////////////////////////////

	bht_table u_bht_table (
		.CLK(CLK),
		.nrst(nrst),
		.en(en),
		.if_set(if_set),
		.id_set(id_set),
		.exe_set(exe_set),
		.if_ways(if_ways),
		.id_ways(id_ways),
		.exe_ways(exe_ways),
		.alloc(alloc),
		.upd(upd)
	);

	//////////////////////////////
	// fetch lookup
	//////////////////////////////

	assign if_set = bp_pkg::pc_set(if_pc);

	// a miss returns a zero entry so no hit qualifier is needed
	bht_way_match u_if_match (
		.set_entries(if_ways),
		.tag(bp_pkg::pc_tag(if_pc)),
		.hit(),
		.way(),
		.entry(if_entry)
	);

	assign if_out.prediction = if_entry.ctr[bp_pkg::CTR_W-1];
	assign if_out.pbt = if_entry.target;

	//////////////////////////////
	// decode and execute
	//////////////////////////////

	bp_decode_stage u_decode (
		.id_in(id_in),
		.id_ways(id_ways),
		.id_set(id_set),
		.alloc(alloc),
		.jump_alloc(jump_alloc),
		.id_jump_in_bht(id_jump_in_bht)
	);

	bp_resolve_stage u_resolve (
		.exe_in(exe_in),
		.exe_ways(exe_ways),
		.exe_set(exe_set),
		.upd(upd),
		.mispredict(mispredict),
		.exe_correction(exe_correction),
		.exe_pbt(exe_pbt),
		.exe_cni(exe_cni)
	);

	bp_flush_ctrl u_flush (
		.CLK(CLK),
		.nrst(nrst),
		.en(en),
		.mispredict(mispredict),
		.jump_alloc(jump_alloc),
		.flush(flush)
	);

endmodule

`default_nettype wire

// ==== bench/bp_properties.sv ====
`timescale 1ns/1ns
`default_nettype none

module bp_properties (
	input logic CLK,
	input logic nrst,
	input logic en,
	input logic flush,
	input logic mispredict,
	// one table row as seen on a read port and its set index
	input logic [bp_pkg::SET_W-1:0] rd_set,
	input bp_pkg::bht_set_t rd_row
);

	// the extension covers one enabled cycle only
	// so a third flush in a row needs a recent mispredict
	property p_flush_bounded;
		@(posedge CLK) disable iff (!nrst)
			(flush && $past(flush && en) && $past(flush && en, 2)) |->
				(mispredict || $past(mispredict));
	endproperty

	// a stalled edge leaves the observed row as it was
	property p_no_write_stalled;
		@(posedge CLK) disable iff (!nrst)
			(!$past(en) && $past(nrst) && $stable(rd_set)) |-> $stable(rd_row);
	endproperty

	// a reset edge leaves the observed row cleared
	// even with a write request present
	property p_no_write_in_reset;
		@(posedge CLK) $past(!nrst) |-> (rd_row == '0);
	endproperty

	a_flush_bounded: assert property (p_flush_bounded)
		else $error("flush held three cycles with no new mispredict");
	a_no_write_stalled: assert property (p_no_write_stalled)
		else $error("table row changed while en was low");
	a_no_write_in_reset: assert property (p_no_write_in_reset)
		else $error("table row not cleared by reset");

endmodule

//////////////////////////////
// table contents
//////////////////////////////

// observed through the fetch read port
bind bht_table bp_properties u_table_props (
	.CLK(CLK),
	.nrst(nrst),
	.en(en),
	.flush(1'b0),
	.mispredict(1'b0),
	.rd_set(if_set),
	.rd_row(if_ways)
);

//////////////////////////////
// flush sequence
//////////////////////////////

bind bp_flush_ctrl bp_properties u_flush_props (
	.CLK(CLK),
	.nrst(nrst),
	.en(en),
	.flush(flush),
	.mispredict(mispredict),
	.rd_set('0),
	.rd_row('0)
);

`default_nettype wire

// ==== bench/tb_branch_predictor.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_branch_predictor;

	localparam int N_CYCLES = 2000;
	localparam int N_SWEEP = 16;

	logic CLK;
	logic nrst;
	logic en;
	logic [bp_pkg::PC_W-1:0] if_pc;
	bp_pkg::bp_decode_t id_in;
	bp_pkg::bp_exe_t exe_in;
	bp_pkg::bp_fetch_t if_out;
	bp_pkg::bp_correction_e exe_correction;
	logic [bp_pkg::PC_W-1:0] exe_pbt;
	logic [bp_pkg::PC_W-1:0] exe_cni;
	logic flush;
	logic id_jump_in_bht;

	// branch kind at execute, 0..5 btype, 6..7 compressed, 8 none
	int exe_kind;

	// reference table, fifo pointers and flush extension
	bp_pkg::bht_entry_t model_mem [bp_pkg::SETS][bp_pkg::WAYS];
	logic [bp_pkg::WAY_W-1:0] model_ptr [bp_pkg::SETS];
	logic model_pend;

	// event counts for the end of run
	int n_replace;
	int n_update;
	int n_collide;
	int n_mispredict;
	int n_jump_hit;

	branch_predictor u_branch_predictor (
		.CLK(CLK),
		.nrst(nrst),
		.en(en),
		.if_pc(if_pc),
		.id_in(id_in),
		.exe_in(exe_in),
		.if_out(if_out),
		.exe_correction(exe_correction),
		.exe_pbt(exe_pbt),
		.exe_cni(exe_cni),
		.flush(flush),
		.id_jump_in_bht(id_jump_in_bht)
	);

	initial CLK = 1'b0;
	always #20 CLK = ~CLK;

	//////////////////////////////
	// failure reporting
	//////////////////////////////

	task automatic fail_stop();
		$display("Regression failed");
		$fatal(1, "simulation stopped at first failure");
	endtask

	task automatic report_mismatch(input string msg);
		$display("Error at %0t ns: %s", $time, msg);
		fail_stop();
	endtask

	task automatic check_fetch(input bp_pkg::bp_fetch_t got, input bp_pkg::bp_fetch_t exp);
		if (got !== exp)
			report_mismatch($sformatf("fetch pc %h gave pred %b pbt %h, expected %b %h",
				if_pc, got.prediction, got.pbt, exp.prediction, exp.pbt));
	endtask

	task automatic check_correction(input bp_pkg::bp_correction_e got,
		input bp_pkg::bp_correction_e exp, input logic [bp_pkg::PC_W-1:0] got_pbt,
		input logic [bp_pkg::PC_W-1:0] exp_pbt, input logic [bp_pkg::PC_W-1:0] got_cni,
		input logic [bp_pkg::PC_W-1:0] exp_cni);
		if (got !== exp || got_pbt !== exp_pbt || got_cni !== exp_cni)
			report_mismatch($sformatf("exe pc %h gave %s pbt %h cni %h, expected %s %h %h",
				exe_in.pc, got.name(), got_pbt, got_cni, exp.name(), exp_pbt, exp_cni));
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp)
			report_mismatch($sformatf("%s is %b, expected %b", name, got, exp));
	endtask

	//////////////////////////////
	// reference model
	//////////////////////////////

	task automatic clear_model();
		for (int s = 0; s < bp_pkg::SETS; s++) begin
			model_ptr[s] = '0;
			for (int w = 0; w < bp_pkg::WAYS; w++)
				model_mem[s][w] = '0;
		end
		model_pend = 1'b0;
	endtask

	// hit only when exactly one valid way carries pc[9:4]
	task automatic model_lookup(input logic [bp_pkg::PC_W-1:0] pc, output logic hit,
		output logic [bp_pkg::WAY_W-1:0] way, output bp_pkg::bht_entry_t entry);
		int hits;
		logic [3:0] s;
		hits = 0;
		s = pc[3:0];
		way = '0;
		entry = '0;
		for (int w = 0; w < bp_pkg::WAYS; w++) begin
			if (model_mem[s][w].valid && model_mem[s][w].tag == pc[9:4]) begin
				hits++;
				way = w[1:0];
				entry = model_mem[s][w];
			end
		end
		hit = (hits == 1);
		if (!hit) begin
			way = '0;
			entry = '0;
		end
	endtask

	// compare outputs of this cycle, then step the model as the edge will
	task automatic check_and_update();
		logic if_hit;
		logic id_hit;
		logic exe_hit;
		logic [bp_pkg::WAY_W-1:0] no_way;
		logic [bp_pkg::WAY_W-1:0] exe_way;
		bp_pkg::bht_entry_t if_e;
		bp_pkg::bht_entry_t id_e;
		bp_pkg::bht_entry_t exe_e;
		bp_pkg::bp_fetch_t exp_fetch;
		bp_pkg::bp_correction_e exp_corr;
		logic alloc_we;
		logic jump_new;
		logic taken;
		logic is_branch;
		logic mispred;
		logic [bp_pkg::CTR_W-1:0] new_ctr;
		logic [3:0] s;
		model_lookup(if_pc, if_hit, no_way, if_e);
		model_lookup(id_in.pc, id_hit, no_way, id_e);
		model_lookup(exe_in.pc, exe_hit, exe_way, exe_e);

		// fetch takes the counter msb and target of a hit
		exp_fetch.prediction = if_hit && if_e.ctr[1];
		exp_fetch.pbt = if_hit ? if_e.target : 11'd0;
		check_fetch(if_out, exp_fetch);

		alloc_we = (id_in.is_jump || id_in.is_btype) && !id_hit;
		jump_new = id_in.is_jump && !id_hit;
		check_flag("id_jump_in_bht", id_jump_in_bht, id_in.is_jump && id_hit);

		// beq beqz on z, bne bnez on !z, blt bltu on less, bge bgeu on !less
		is_branch = (exe_kind < 8);
		case (exe_kind)
			0, 6: taken = exe_in.z;
			1, 7: taken = !exe_in.z;
			2, 4: taken = exe_in.less;
			3, 5: taken = !exe_in.less;
			default: taken = 1'b0;
		endcase
		mispred = is_branch && ((exe_hit && exe_e.ctr[1]) != taken);
		if (!mispred)
			exp_corr = bp_pkg::NONE;
		else if (taken)
			exp_corr = bp_pkg::PBT;
		else
			exp_corr = bp_pkg::CNI;
		check_correction(exe_correction, exp_corr, exe_pbt, exe_hit ? exe_e.target : 11'd0,
			exe_cni, exe_in.pc + 11'd1);
		check_flag("flush", flush, model_pend || mispred);

		// state only moves on an enabled edge
		if (en) begin
			s = id_in.pc[3:0];
			if (alloc_we) begin
				if (model_mem[s][model_ptr[s]].valid)
					n_replace++;
				if (is_branch && exe_hit)
					n_collide++;
				model_mem[s][model_ptr[s]].valid = 1'b1;
				model_mem[s][model_ptr[s]].tag = id_in.pc[9:4];
				model_mem[s][model_ptr[s]].target = id_in.target;
				model_mem[s][model_ptr[s]].ctr =
					id_in.is_jump ? bp_pkg::CTR_JUMP_INIT : bp_pkg::CTR_BRANCH_INIT;
				model_ptr[s] = model_ptr[s] + 2'd1;
			end else if (is_branch && exe_hit) begin
				new_ctr = exe_e.ctr;
				if (taken && new_ctr != 2'd3)
					new_ctr = new_ctr + 2'd1;
				else if (!taken && new_ctr != 2'd0)
					new_ctr = new_ctr - 2'd1;
				model_mem[exe_in.pc[3:0]][exe_way].ctr = new_ctr;
				n_update++;
			end
			if (model_pend)
				model_pend = 1'b0;
			else
				model_pend = mispred || jump_new;
		end
		if (mispred)
			n_mispredict++;
		if (id_in.is_jump && id_hit)
			n_jump_hit++;
	endtask

	//////////////////////////////
	// stimulus
	//////////////////////////////

	// two sets with six tags each, so ways get replaced
	function automatic logic [bp_pkg::PC_W-1:0] pool_pc();
		int unsigned r;
		logic [5:0] tag;
		r = $urandom;
		tag = 6'(r[15:8] % 8'd6);
		return {r[0], tag, r[4] ? 4'd3 : 4'd9};
	endfunction

	task automatic drive_idle();
		en = 1'b1;
		if_pc = '0;
		id_in = '0;
		exe_in = '0;
		exe_kind = 8;
	endtask

	task automatic drive_random();
		int unsigned r;
		r = $urandom;
		// mostly enabled, some stall cycles
		en = (r[2:0] != 3'd0);
		if_pc = pool_pc();
		id_in.pc = pool_pc();
		id_in.target = r[18:8];
		id_in.is_jump = (r[20:19] == 2'd2);
		id_in.is_btype = r[19];
		r = $urandom;
		exe_in.pc = pool_pc();
		exe_in.z = r[4];
		exe_in.less = r[5];
		exe_kind = int'(r[15:8] % 8'd10);
		exe_in.btype = '0;
		exe_in.c_btype = '0;
		if (exe_kind < 6)
			exe_in.btype = 6'b100000 >> exe_kind;
		else if (exe_kind < 8)
			exe_in.c_btype = 2'b10 >> (exe_kind - 6);
		else
			exe_kind = 8;
	endtask

	task automatic run_cycles();
		for (int c = 0; c < N_CYCLES; c++) begin
			@(posedge CLK);
			#2;
			// first walk every fetch set on the empty table
			if (c < N_SWEEP) begin
				drive_idle();
				if_pc = 11'(c * 37);
			end else begin
				drive_random();
			end
			@(negedge CLK);
			check_and_update();
		end
	endtask

	initial begin
		logic settled;
		drive_idle();
		// a branch at pc 0 requests allocation all through reset
		// and must not land in the table
		id_in.pc = '0;
		id_in.target = 11'h2a5;
		id_in.is_btype = 1'b1;
		nrst = 1'b0;
		n_replace = 0;
		n_update = 0;
		n_collide = 0;
		n_mispredict = 0;
		n_jump_hit = 0;
		clear_model();
		void'($urandom(12));
		repeat (2) @(posedge CLK);
		#2;
		nrst = 1'b1;
		id_in = '0;
		settled = 1'b0;
		for (int i = 0; i < 10 && !settled; i++) begin
			@(negedge CLK);
			settled = (flush === 1'b0) && (if_out === '0) && (exe_correction === bp_pkg::NONE);
		end
		if (!settled) begin
			$display("outputs did not come out of reset idle within 10 cycles");
			fail_stop();
		end else begin
			run_cycles();
			$display("replace %0d update %0d collide %0d mispredict %0d jump hit %0d",
				n_replace, n_update, n_collide, n_mispredict, n_jump_hit);
			if (n_replace > 0 && n_update > 0 && n_collide > 0 && n_mispredict > 0 &&
				n_jump_hit > 0) begin
				$display("Regression passed");
				$finish;
			end else begin
				$display("random run missed replacement, update, collision, mispredict or jump hit");
				fail_stop();
			end
		end
	end

endmodule

`default_nettype wire

// ==== flist.f ====
hw/bp_pkg.sv
hw/bht_way_match.sv
hw/bht_table.sv
hw/bp_decode_stage.sv
hw/bp_resolve_stage.sv
hw/bp_flush_ctrl.sv
hw/branch_predictor.sv
bench/bp_properties.sv
bench/tb_branch_predictor.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS = --binary --timing --assert -j 0
TOP = tb_branch_predictor
FLIST = flist.f
OBJ_DIR = obj_dir

.PHONY: sim clean

# build and run, exit status follows the simulation
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
